// File: rtc_write_ctrl.f
src/rtc_reg_pkg.sv
src/panel_pkg.sv
src/key_if.sv
src/key_strobe.sv
src/init_timer.sv
src/field_editor.sv
src/rtc_write_ctrl.sv
sim/rtc_write_checker.sv
sim/rtc_write_monitor.sv
sim/rtc_write_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f rtc_write_ctrl.f --top-module rtc_write_ctrl_tb \
  -o rtc_write_sim > build.log 2>&1 \
  && ./obj_dir/rtc_write_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "build or simulation ended with an error status"
cat sim.log 2>/dev/null || cat build.log
grep -q "All tests passed!" sim.log 2>/dev/null && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }

// File: sim/rtc_write_ctrl_tb.sv
`timescale 1ns/100ps

module rtc_write_ctrl_tb;

  localparam int PRESS_LIMIT = 4;
  localparam int INIT_HOLD   = 16;

  logic            clk;
  logic            reset;
  logic            restart_i;
  logic            rw_i;
  logic            up_i;
  logic            down_i;
  logic            left_i;
  logic            right_i;
  logic [7:0][7:0] bank;  // index 0 is seconds
  logic            init_o;
  logic [7:0]      address_o;
  logic [7:0]      data_o;
  int              err_cnt;
  int              edit_cnt;
  int              fired;
  logic [7:0]      visited;
  logic [31:0]     lfsr_q;
  int              err_base    = 0;
  int              edit_base   = 0;
  int              fired_base  = 0;
  int              extra_fails = 0;
  int              pass_cnt    = 0;
  int              fail_cnt    = 0;

  rtc_write_ctrl #(
    .PRESS_LIMIT (PRESS_LIMIT),
    .INIT_HOLD   (INIT_HOLD)
  ) DUT (
    .clk        (clk),
    .reset      (reset),
    .restart_i  (restart_i),
    .rw_i       (rw_i),
    .up_i       (up_i),
    .down_i     (down_i),
    .left_i     (left_i),
    .right_i    (right_i),
    .seconds_i  (bank[0]),
    .minutes_i  (bank[1]),
    .hours_i    (bank[2]),
    .date_i     (bank[3]),
    .month_i    (bank[4]),
    .year_i     (bank[5]),
    .weekday_i  (bank[6]),
    .week_num_i (bank[7]),
    .init_o     (init_o),
    .address_o  (address_o),
    .data_o     (data_o)
  );

  rtc_write_monitor #(
    .PRESS_LIMIT (PRESS_LIMIT),
    .INIT_HOLD   (INIT_HOLD)
  ) u_monitor (
    .clk        (clk),
    .reset      (reset),
    .restart_i  (restart_i),
    .rw_i       (rw_i),
    .buttons_i  ({right_i, left_i, down_i, up_i}),
    .bank_i     (bank),
    .init_i     (init_o),
    .address_i  (address_o),
    .data_i     (data_o),
    .err_cnt_o  (err_cnt),
    .edit_cnt_o (edit_cnt),
    .visited_o  (visited)
  );

  bind field_editor rtc_write_checker u_checker (
    .clk       (clk),
    .pulses_i  ({keys.right, keys.left, keys.down, keys.up}),
    .init_i    (init_o),
    .address_i (address_o),
    .data_i    (data_o)
  );

  assign fired = DUT.u_field_editor.u_checker.fired_cnt;

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic fill_bank;
    logic [31:0] val;
    for (int i = 0; i < 8; i++)
    begin
      take_bits(8, val);
      bank[i] <= val[7:0];
    end
  endtask

  // hold is the number of rising edges that sample the pattern
  task automatic drive_press(input logic [3:0] pattern, input int hold);
    @(posedge clk);
    {right_i, left_i, down_i, up_i} <= pattern;
    repeat (hold) @(posedge clk);
    {right_i, left_i, down_i, up_i} <= 4'b0000;
    repeat (2) @(posedge clk);
  endtask

  task automatic wait_field_entry(input int limit);
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (address_o != 8'h21 && cycles < limit);
    if (address_o != 8'h21)
    begin
      $display("timeout: seconds field not entered within %0d cycles", limit);
      extra_fails++;
    end
  endtask

  task automatic end_test(input int num, input string name, input int exp_edits);
    int errs;
    errs = (err_cnt - err_base) + (fired - fired_base) + extra_fails;
    if (edit_cnt - edit_base != exp_edits)
    begin
      $display("edited data shown in %0d cycles instead of %0d", edit_cnt - edit_base,
               exp_edits);
      errs++;
    end
    if (errs == 0)
    begin
      $display("test %0d %s: pass", num, name);
      pass_cnt++;
    end
    else
    begin
      $display("test %0d %s: FAIL with %0d problems", num, name, errs);
      fail_cnt++;
    end
    err_base    = err_cnt;
    edit_base   = edit_cnt;
    fired_base  = fired;
    extra_fails = 0;
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] h;
    logic [31:0] idx;
    int          n_edit;
    lfsr_q    = 32'h46fc_2230;
    reset     = 1'b1;
    restart_i = 1'b0;
    rw_i      = 1'b0;
    up_i      = 1'b0;
    down_i    = 1'b0;
    left_i    = 1'b0;
    right_i   = 1'b0;
    bank      = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    wait_field_entry(4 * INIT_HOLD);
    end_test(1, "reset and initialization", 0);

    @(posedge clk);
    fill_bank;
    for (int k = 0; k < 8; k++)
    begin
      take_bits(1, r);
      take_bits(2, h);
      drive_press(r[0] ? 4'b0001 : 4'b0010, PRESS_LIMIT + 1 + int'(h));
    end
    end_test(2, "up and down edits", 8);

    @(posedge clk);
    fill_bank;
    for (int k = 0; k < 16; k++)
    begin
      take_bits(1, r);
      take_bits(2, h);
      drive_press((k >= 8 || r[0]) ? 4'b1000 : 4'b0100, PRESS_LIMIT + 1 + int'(h));
    end
    if (visited != 8'hff)
    begin
      $display("not every field was shown during navigation");
      extra_fails++;
    end
    end_test(3, "field navigation", 0);

    for (int k = 0; k < 10; k++)
    begin
      take_bits(2, idx);
      take_bits(2, h);
      if (k < 6)
        drive_press(4'b0001 << idx[1:0], 1 + int'(h));  // never reaches the limit
      else
        drive_press((4'b0001 << idx[1:0]) | (4'b0001 << (idx[1:0] + 2'd1 + {1'b0, h[0]})),
                    PRESS_LIMIT + 2 + int'(h));
    end
    end_test(4, "short presses and chords", 0);

    n_edit = 0;
    for (int k = 0; k < 6; k++)
    begin
      take_bits(1, r);
      take_bits(2, idx);
      @(posedge clk);
      rw_i <= (k == 0) ? 1'b1 : r[0];
      if (k != 0 && !r[0] && !idx[1])
        n_edit++;  // up or down while writing
      drive_press(4'b0001 << idx[1:0], PRESS_LIMIT + 2);
    end
    @(posedge clk);
    rw_i <= 1'b0;
    repeat (2) @(posedge clk);
    end_test(5, "read/write idle", n_edit);

    for (int k = 0; k < 3; k++)
    begin
      repeat (k + 1) drive_press(4'b1000, PRESS_LIMIT + 1);
      take_bits(2, h);
      @(posedge clk);
      restart_i <= 1'b1;
      repeat (int'(h) + 1) @(posedge clk);
      restart_i <= 1'b0;
      wait_field_entry(4 * INIT_HOLD);
    end
    end_test(6, "restart from a field", 0);

    $display("tests passed %0d, failed %0d, monitor errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: sim/rtc_write_monitor.sv
`timescale 1ns/100ps

module rtc_write_monitor #(
  parameter int PRESS_LIMIT = panel_pkg::DEF_PRESS_LIMIT,
  parameter int INIT_HOLD   = panel_pkg::DEF_INIT_HOLD
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            restart_i,
  input  logic            rw_i,
  input  logic [3:0]      buttons_i,
  input  logic [7:0][7:0] bank_i,     // index 0 is seconds
  input  logic            init_i,
  input  logic [7:0]      address_i,
  input  logic [7:0]      data_i,
  output int              err_cnt_o,
  output int              edit_cnt_o,
  output logic [7:0]      visited_o
);

  import panel_pkg::*;

  int         errs  = 0;
  int         edits = 0;      // cycles with data other than the readback byte
  logic [7:0] seen  = 8'h00;
  int         run_len;        // edges the same lone button was held
  logic [3:0] last_btn;
  logic [3:0] pulse;          // expected one-shot outputs this cycle
  logic       in_init;
  int         settle_cnt;
  logic [2:0] field;
  logic       exp_init;
  logic [7:0] exp_addr;
  logic [7:0] exp_data;
  logic [7:0] offs;

  assign err_cnt_o  = errs;
  assign edit_cnt_o = edits;
  assign visited_o  = seen;

  // inputs change on the rising edge, so the falling edge sees a settled cycle
  always @(negedge clk)
  begin
    exp_init = reset || restart_i;
    exp_addr = 8'h00;
    exp_data = 8'h00;
    if (exp_init)
    begin
      exp_addr = 8'h02;
      exp_data = 8'h10;
    end
    else if (in_init)
      exp_addr = 8'h02;  // settle period writes 0x00
    else if (!rw_i)
    begin
      exp_addr = 8'h21 + {5'd0, field};
      exp_data = bank_i[field];
      if (pulse[KEY_UP])
        exp_data = exp_data + 8'd1;
      else if (pulse[KEY_DOWN])
        exp_data = exp_data - 8'd1;
    end
    if (init_i !== exp_init || address_i !== exp_addr || data_i !== exp_data)
    begin
      $display("ERROR %0t: init %b address %h data %h, expected %b %h %h", $time,
               init_i, address_i, data_i, exp_init, exp_addr, exp_data);
      errs++;
    end
    if (address_i >= 8'h21 && address_i <= 8'h28)
    begin
      offs = address_i - 8'h21;
      seen[offs[2:0]] = 1'b1;
      if (data_i != bank_i[offs[2:0]])
        edits++;
    end
    // step the model over the coming rising edge
    if (reset)
    begin
      in_init    = 1'b1;
      settle_cnt = 0;
      field      = 3'd0;
      run_len    = 0;
      last_btn   = 4'b0000;
      pulse      = 4'b0000;
    end
    else
    begin
      if (restart_i)
      begin
        in_init    = 1'b1;
        settle_cnt = 0;
      end
      else if (in_init)
      begin
        if (settle_cnt > INIT_HOLD)  // done after INIT_HOLD+1 edges, leave one edge later
        begin
          in_init    = 1'b0;
          settle_cnt = 0;
          field      = 3'd0;
        end
        else
          settle_cnt++;
      end
      else if (!rw_i)
      begin
        if (pulse[KEY_RIGHT])
          field = field + 3'd1;
        else if (pulse[KEY_LEFT])
          field = field - 3'd1;
      end
      if ($countones(buttons_i) != 1)
        run_len = 0;
      else if (buttons_i != last_btn)
        run_len = 1;
      else if (run_len < PRESS_LIMIT + 2)
        run_len++;
      last_btn = buttons_i;
      pulse    = (run_len == PRESS_LIMIT + 1) ? buttons_i : 4'b0000;
    end
  end

endmodule

// File: sim/rtc_write_checker.sv
`timescale 1ns/100ps

module rtc_write_checker (
  input logic       clk,
  input logic [3:0] pulses_i,
  input logic       init_i,
  input logic [7:0] address_i,
  input logic [7:0] data_i
);

  int fired_cnt = 0;  // read by the testbench at the end of each test

  one_pulse: assert property (@(posedge clk) $countones(pulses_i) <= 1)
  else
  begin
    $error("more than one key pulse in the same cycle");
    fired_cnt++;
  end

  addr_legal: assert property (@(posedge clk)
    address_i inside {8'h00, 8'h02, [8'h21:8'h28]})
  else
  begin
    $error("address %h outside the register map", address_i);
    fired_cnt++;
  end

  init_ctrl: assert property (@(posedge clk)
    init_i |-> (address_i == 8'h02 && data_i == 8'h10))
  else
  begin
    $error("init high without control register write");
    fired_cnt++;
  end

endmodule

// File: src/rtc_write_ctrl.sv
`timescale 1ns/100ps

module rtc_write_ctrl #(
  parameter int PRESS_LIMIT = panel_pkg::DEF_PRESS_LIMIT,
  parameter int INIT_HOLD   = panel_pkg::DEF_INIT_HOLD
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       restart_i,
  input  logic       rw_i,
  input  logic       up_i,
  input  logic       down_i,
  input  logic       left_i,
  input  logic       right_i,
  input  logic [7:0] seconds_i,
  input  logic [7:0] minutes_i,
  input  logic [7:0] hours_i,
  input  logic [7:0] date_i,
  input  logic [7:0] month_i,
  input  logic [7:0] year_i,
  input  logic [7:0] weekday_i,
  input  logic [7:0] week_num_i,
  output logic       init_o,
  output logic [7:0] address_o,
  output logic [7:0] data_o
);

  import panel_pkg::*;
  import rtc_reg_pkg::*;

  logic [3:0] buttons;
  time_bank_u bank;
  logic       in_init;
  logic       settle_done;

  assign buttons[KEY_UP]    = up_i;
  assign buttons[KEY_DOWN]  = down_i;
  assign buttons[KEY_LEFT]  = left_i;
  assign buttons[KEY_RIGHT] = right_i;

  assign bank.field.seconds  = seconds_i;
  assign bank.field.minutes  = minutes_i;
  assign bank.field.hours    = hours_i;
  assign bank.field.date     = date_i;
  assign bank.field.month    = month_i;
  assign bank.field.year     = year_i;
  assign bank.field.weekday  = weekday_i;
  assign bank.field.week_num = week_num_i;

  key_if keys ();

  key_strobe #(
    .PRESS_LIMIT (PRESS_LIMIT)
  ) u_key_strobe (
    .clk       (clk),
    .reset     (reset),
    .buttons_i (buttons),
    .keys      (keys.src)
  );

  init_timer #(
    .INIT_HOLD (INIT_HOLD)
  ) u_init_timer (
    .clk           (clk),
    .reset         (reset),
    .restart_i     (restart_i),
    .in_init_i     (in_init),
    .settle_done_o (settle_done)
  );

  field_editor u_field_editor (
    .clk           (clk),
    .reset         (reset),
    .restart_i     (restart_i),
    .rw_i          (rw_i),
    .settle_done_i (settle_done),
    .bank_i        (bank),
    .keys          (keys.dst),
    .in_init_o     (in_init),
    .init_o        (init_o),
    .address_o     (address_o),
    .data_o        (data_o)
  );

endmodule

// File: src/field_editor.sv
`timescale 1ns/100ps

module field_editor (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    restart_i,
  input  logic                    rw_i,
  input  logic                    settle_done_i,
  input  rtc_reg_pkg::time_bank_u bank_i,
  key_if.dst                      keys,
  output logic                    in_init_o,
  output logic                    init_o,
  output logic [7:0]              address_o,
  output logic [7:0]              data_o
);

  import rtc_reg_pkg::*;

  logic       init_q;
  field_t     field_q;
  logic       hold;
  logic [7:0] cur_byte;

  assign hold     = reset || restart_i;
  assign cur_byte = bank_i.bytes[field_q];  // readback of the selected field

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      init_q  <= 1'b1;
      field_q <= FLD_SEC;
    end
    else if (restart_i)
    begin
      init_q <= 1'b1;
    end
    else if (init_q)
    begin
      if (settle_done_i)
      begin
        init_q  <= 1'b0;
        field_q <= FLD_SEC;  // always start editing at seconds
      end
    end
    else if (!rw_i)
    begin
      if (keys.right)
        field_q <= field_t'(field_q + 3'd1);  // 3-bit wrap
      else if (keys.left)
        field_q <= field_t'(field_q - 3'd1);
    end
  end

  assign in_init_o = init_q;
  assign init_o    = hold;

  always_comb
  begin
    address_o = IDLE_ADDR;
    data_o    = 8'h00;
    if (hold)
    begin
      address_o = CTRL_ADDR;
      data_o    = CTRL_HOLD_DATA;
    end
    else if (init_q)
    begin
      address_o = CTRL_ADDR;
      data_o    = CTRL_RUN_DATA;
    end
    else if (!rw_i)
    begin
      address_o = FIELD_BASE_ADDR + {5'd0, field_q};
      if (keys.up)
        data_o = cur_byte + 8'd1;
      else if (keys.down)
        data_o = cur_byte - 8'd1;
      else
        data_o = cur_byte;
    end
  end

endmodule

// File: src/init_timer.sv
`timescale 1ns/100ps

module init_timer #(
  parameter int INIT_HOLD = panel_pkg::DEF_INIT_HOLD
) (
  input  logic clk,
  input  logic reset,
  input  logic restart_i,
  input  logic in_init_i,
  output logic settle_done_o
);

  localparam int CNT_W = $clog2(INIT_HOLD + 1);

  logic [CNT_W-1:0] settle_cnt_q;
  logic             done_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      settle_cnt_q <= '0;
      done_q       <= 1'b0;
    end
    else if (!in_init_i || restart_i)
    begin
      settle_cnt_q <= '0;  // held clear outside the settle period
      done_q       <= 1'b0;
    end
    else
    begin
      if (settle_cnt_q != CNT_W'(INIT_HOLD))
        settle_cnt_q <= settle_cnt_q + 1'b1;
      if (settle_cnt_q == CNT_W'(INIT_HOLD))
        done_q <= 1'b1;  // stays set until in_init drops
    end
  end

  assign settle_done_o = done_q;

endmodule

// File: src/key_strobe.sv
`timescale 1ns/100ps

module key_strobe #(
  parameter int PRESS_LIMIT = panel_pkg::DEF_PRESS_LIMIT
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [3:0] buttons_i,
  key_if.src         keys
);

  import panel_pkg::*;

  localparam int CNT_W = $clog2(PRESS_LIMIT + 2);

  logic [CNT_W-1:0] hold_cnt_q;
  logic [3:0]       last_q;
  logic [3:0]       pulse_q;
  logic             single;
  logic             same;

  assign single = $onehot(buttons_i);
  assign same   = single && (buttons_i == last_q);  // same lone button as last edge

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hold_cnt_q <= '0;
      last_q     <= '0;
      pulse_q    <= '0;
    end
    else
    begin
      last_q  <= buttons_i;
      pulse_q <= '0;
      if (!single)
        hold_cnt_q <= '0;  // release or chord
      else if (!same)
        hold_cnt_q <= CNT_W'(1);
      else if (hold_cnt_q <= CNT_W'(PRESS_LIMIT))
        hold_cnt_q <= hold_cnt_q + 1'b1;  // stops at PRESS_LIMIT+1, one pulse per press
      if (same && hold_cnt_q == CNT_W'(PRESS_LIMIT))
        pulse_q <= buttons_i;
    end
  end

  assign keys.up    = pulse_q[KEY_UP];
  assign keys.down  = pulse_q[KEY_DOWN];
  assign keys.left  = pulse_q[KEY_LEFT];
  assign keys.right = pulse_q[KEY_RIGHT];

endmodule

// File: src/key_if.sv
`timescale 1ns/100ps

interface key_if;

  logic up;     // one-cycle pulses, never two at once
  logic down;
  logic left;
  logic right;

  modport src (
    output up, down, left, right
  );

  modport dst (
    input up, down, left, right
  );

endinterface

// File: src/panel_pkg.sv
package panel_pkg;

  // bit positions in the button vector
  localparam logic [1:0] KEY_UP    = 2'd0;
  localparam logic [1:0] KEY_DOWN  = 2'd1;
  localparam logic [1:0] KEY_LEFT  = 2'd2;
  localparam logic [1:0] KEY_RIGHT = 2'd3;

  localparam int DEF_PRESS_LIMIT = 256;  // hold cycles before a pulse
  localparam int DEF_INIT_HOLD   = 768;  // settle cycles after restart

endpackage

// File: src/rtc_reg_pkg.sv
package rtc_reg_pkg;

  // editable fields in chip order, index is the offset from the seconds address
  typedef enum logic [2:0] {
    FLD_SEC      = 3'd0,
    FLD_MIN      = 3'd1,
    FLD_HOUR     = 3'd2,
    FLD_DATE     = 3'd3,
    FLD_MONTH    = 3'd4,
    FLD_YEAR     = 3'd5,
    FLD_WEEKDAY  = 3'd6,
    FLD_WEEK_NUM = 3'd7
  } field_t;

  localparam logic [7:0] FIELD_BASE_ADDR = 8'h21;  // seconds
  localparam logic [7:0] CTRL_ADDR       = 8'h02;
  localparam logic [7:0] CTRL_HOLD_DATA  = 8'h10;  // while restart held
  localparam logic [7:0] CTRL_RUN_DATA   = 8'h00;  // settle period
  localparam logic [7:0] IDLE_ADDR       = 8'h00;

  // seconds sits in the low byte so that bytes[FLD_SEC] picks it
  typedef struct packed {
    logic [7:0] week_num;
    logic [7:0] weekday;
    logic [7:0] year;
    logic [7:0] month;
    logic [7:0] date;
    logic [7:0] hours;
    logic [7:0] minutes;
    logic [7:0] seconds;
  } time_fields_t;

  typedef union packed {
    time_fields_t    field;  // filled by name at the top
    logic [7:0][7:0] bytes;  // read by field index
  } time_bank_u;

endpackage
